//--- rtl/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int LINE_BEATS = 16;
	localparam int LINE_W = LINE_BEATS * DATA_W; // one cache line, 512 bits
	localparam int BEAT_CNT_W = 4;

	// AXI3 length codes, beats minus one
	localparam logic [3:0] LEN_LINE = 4'd15;
	localparam logic [3:0] LEN_SINGLE = 4'd0;

	localparam logic [1:0] BURST_FIXED = 2'd0;
	localparam logic [1:0] BURST_INCR = 2'd1;

	// read ids tell the returning beats apart
	localparam logic [3:0] ID_ICACHE = 4'd0;
	localparam logic [3:0] ID_DCACHE = 4'd1;

	typedef enum logic [1:0]
	{
		RD_IDLE,
		RD_REQ,
		RD_RESP,
		RD_FINISH
	} rd_state_t;

	typedef enum logic [2:0]
	{
		WR_IDLE,
		WR_REQ,
		WR_DATA,
		WR_RESP,
		WR_FINISH
	} wr_state_t;

endpackage

`default_nettype wire

//--- rtl/axi_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_port import axi_bridge_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire wr_busy,

	input wire icache_rd_req,
	input wire [2:0] icache_rd_type,
	input wire [ADDR_W-1:0] icache_rd_addr,
	output logic icache_rd_rdy,
	output logic icache_ret_valid,
	output logic icache_ret_last,
	output logic [DATA_W-1:0] icache_ret_data,

	input wire dcache_rd_req,
	input wire [2:0] dcache_rd_type,
	input wire [ADDR_W-1:0] dcache_rd_addr,
	input wire dcache_rd_uncached,
	output logic dcache_rd_rdy,
	output logic dcache_ret_valid,
	output logic dcache_ret_last,
	output logic [DATA_W-1:0] dcache_ret_data,

	output logic arvalid,
	output logic [3:0] arid,
	output logic [ADDR_W-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	input wire arready,

	input wire rvalid,
	input wire [3:0] rid,
	input wire [DATA_W-1:0] rdata,
	input wire rlast
);

	rd_state_t state;
	rd_state_t state_nxt;
	logic can_accept;
	logic icache_acc;
	logic dcache_acc;
	logic beat_ok;

	// finish behaves like idle, a new read may start right away
	assign can_accept = (state == RD_IDLE || state == RD_FINISH) && !wr_busy;
	assign icache_rd_rdy = can_accept;
	assign dcache_rd_rdy = can_accept && !icache_rd_req; // icache has priority

	assign icache_acc = icache_rd_req && icache_rd_rdy;
	assign dcache_acc = dcache_rd_req && dcache_rd_rdy;

	always_comb
	begin
		state_nxt = state;
		case (state)
			RD_IDLE, RD_FINISH:
			begin
				if (icache_acc || dcache_acc)
					state_nxt = RD_REQ;
				else
					state_nxt = RD_IDLE;
			end
			RD_REQ:
			begin
				if (arready)
					state_nxt = RD_RESP;
			end
			RD_RESP:
			begin
				if (rvalid && rlast)
					state_nxt = RD_FINISH;
			end
			default: state_nxt = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= RD_IDLE;
		else
			state <= state_nxt;
	end

	// AR fields latched at acceptance, held through the address phase
	always_ff @(posedge clk)
	begin
		if (icache_acc)
		begin
			arid <= ID_ICACHE;
			araddr <= icache_rd_addr;
			arsize <= icache_rd_type;
			arlen <= LEN_LINE; // instruction fetch is always a full line
			arburst <= BURST_INCR;
		end
		else if (dcache_acc)
		begin
			arid <= ID_DCACHE;
			araddr <= dcache_rd_addr;
			arsize <= dcache_rd_type;
			arlen <= dcache_rd_uncached ? LEN_SINGLE : LEN_LINE;
			arburst <= dcache_rd_uncached ? BURST_FIXED : BURST_INCR;
		end
	end

	assign arvalid = (state == RD_REQ);

	// route each R beat by its id
	assign beat_ok = (state == RD_RESP) && rvalid;
	assign icache_ret_valid = beat_ok && (rid == ID_ICACHE);
	assign dcache_ret_valid = beat_ok && (rid == ID_DCACHE);
	assign icache_ret_last = icache_ret_valid && rlast;
	assign dcache_ret_last = dcache_ret_valid && rlast;
	assign icache_ret_data = rdata;
	assign dcache_ret_data = rdata;

endmodule

`default_nettype wire

//--- rtl/axi_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_port import axi_bridge_pkg::*;
(
	input wire clk,
	input wire rst,

	input wire wr_req,
	input wire [2:0] wr_type,
	input wire [ADDR_W-1:0] wr_addr,
	input wire [3:0] wr_wstrb,
	input wire [LINE_W-1:0] wr_line,
	input wire [DATA_W-1:0] wr_word,
	input wire wr_uncached,
	output logic wr_rdy,
	output logic wr_busy,

	output logic awvalid,
	output logic [ADDR_W-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	input wire awready,

	output logic wvalid,
	output logic [DATA_W-1:0] wdata,
	output logic [3:0] wstrb,
	output logic wlast,
	input wire wready,

	input wire bvalid
);

	wr_state_t state;
	wr_state_t state_nxt;
	logic accept;
	logic beat_done;
	logic uncached_q;
	logic [BEAT_CNT_W-1:0] beat_cnt;
	logic [LINE_W-1:0] line_buf;

	assign wr_rdy = (state == WR_IDLE || state == WR_FINISH);
	assign accept = wr_req && wr_rdy;
	assign beat_done = wvalid && wready;

	// keeps reads off the bus until the B response is in
	assign wr_busy = (state == WR_REQ) || (state == WR_DATA) || (state == WR_RESP);

	always_comb
	begin
		state_nxt = state;
		case (state)
			WR_IDLE, WR_FINISH:
			begin
				if (accept)
					state_nxt = WR_REQ;
				else
					state_nxt = WR_IDLE;
			end
			WR_REQ:
			begin
				if (awready)
					state_nxt = WR_DATA;
			end
			WR_DATA:
			begin
				if (beat_done && wlast)
					state_nxt = WR_RESP;
			end
			WR_RESP:
			begin
				if (bvalid)
					state_nxt = WR_FINISH;
			end
			default: state_nxt = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= WR_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			beat_cnt <= '0;
		else if (accept)
			beat_cnt <= '0;
		else if (beat_done)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// write payload, captured in one cycle
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			awaddr <= wr_addr;
			awsize <= wr_type;
			wstrb <= wr_wstrb;
			uncached_q <= wr_uncached;
			// uncached word sits in the low slot so wdata needs one source
			if (wr_uncached)
				line_buf <= {{(LINE_W-DATA_W){1'b0}}, wr_word};
			else
				line_buf <= wr_line;
		end
		else if (beat_done)
		begin
			line_buf <= {{DATA_W{1'b0}}, line_buf[LINE_W-1:DATA_W]}; // next word down
		end
	end

	assign awvalid = (state == WR_REQ);
	assign awlen = uncached_q ? LEN_SINGLE : LEN_LINE;
	assign awburst = uncached_q ? BURST_FIXED : BURST_INCR;

	assign wvalid = (state == WR_DATA);
	assign wdata = line_buf[DATA_W-1:0]; // low word goes first
	assign wlast = uncached_q || (beat_cnt == BEAT_CNT_W'(LINE_BEATS - 1));

endmodule

`default_nettype wire

//--- rtl/axi_cache_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cache_bridge import axi_bridge_pkg::*;
(
	input wire clk,
	input wire rst,

	// instruction cache reads
	input wire icache_rd_req,
	input wire [2:0] icache_rd_type,
	input wire [ADDR_W-1:0] icache_rd_addr,
	output logic icache_rd_rdy,
	output logic icache_ret_valid,
	output logic icache_ret_last,
	output logic [DATA_W-1:0] icache_ret_data,

	// data cache reads
	input wire dcache_rd_req,
	input wire [2:0] dcache_rd_type,
	input wire [ADDR_W-1:0] dcache_rd_addr,
	input wire dcache_rd_uncached,
	output logic dcache_rd_rdy,
	output logic dcache_ret_valid,
	output logic dcache_ret_last,
	output logic [DATA_W-1:0] dcache_ret_data,

	// data cache writes
	input wire dcache_wr_req,
	input wire [2:0] dcache_wr_type,
	input wire [ADDR_W-1:0] dcache_wr_addr,
	input wire [3:0] dcache_wr_wstrb,
	input wire [LINE_W-1:0] dcache_wr_line,
	input wire [DATA_W-1:0] dcache_wr_word,
	input wire dcache_wr_uncached,
	output logic dcache_wr_rdy,

	output logic arvalid,
	output logic [3:0] arid,
	output logic [ADDR_W-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	input wire arready,

	input wire rvalid,
	input wire [3:0] rid,
	input wire [DATA_W-1:0] rdata,
	input wire rlast,

	output logic awvalid,
	output logic [ADDR_W-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	input wire awready,

	output logic wvalid,
	output logic [DATA_W-1:0] wdata,
	output logic [3:0] wstrb,
	output logic wlast,
	input wire wready,

	input wire bvalid
);

	logic wr_busy; // write in flight, blocks new reads

	axi_read_port axi_read_port_inst
	(
		.clk(clk),
		.rst(rst),
		.wr_busy(wr_busy),
		.icache_rd_req(icache_rd_req),
		.icache_rd_type(icache_rd_type),
		.icache_rd_addr(icache_rd_addr),
		.icache_rd_rdy(icache_rd_rdy),
		.icache_ret_valid(icache_ret_valid),
		.icache_ret_last(icache_ret_last),
		.icache_ret_data(icache_ret_data),
		.dcache_rd_req(dcache_rd_req),
		.dcache_rd_type(dcache_rd_type),
		.dcache_rd_addr(dcache_rd_addr),
		.dcache_rd_uncached(dcache_rd_uncached),
		.dcache_rd_rdy(dcache_rd_rdy),
		.dcache_ret_valid(dcache_ret_valid),
		.dcache_ret_last(dcache_ret_last),
		.dcache_ret_data(dcache_ret_data),
		.arvalid(arvalid),
		.arid(arid),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arready(arready),
		.rvalid(rvalid),
		.rid(rid),
		.rdata(rdata),
		.rlast(rlast)
	);

	axi_write_port axi_write_port_inst
	(
		.clk(clk),
		.rst(rst),
		.wr_req(dcache_wr_req),
		.wr_type(dcache_wr_type),
		.wr_addr(dcache_wr_addr),
		.wr_wstrb(dcache_wr_wstrb),
		.wr_line(dcache_wr_line),
		.wr_word(dcache_wr_word),
		.wr_uncached(dcache_wr_uncached),
		.wr_rdy(dcache_wr_rdy),
		.wr_busy(wr_busy),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.awlen(awlen),
		.awsize(awsize),
		.awburst(awburst),
		.awready(awready),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.wlast(wlast),
		.wready(wready),
		.bvalid(bvalid)
	);

endmodule

`default_nettype wire

//--- dv/axi_cache_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cache_bridge_properties import axi_bridge_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire icache_rd_req,
	input wire icache_rd_rdy,
	input wire dcache_wr_req,
	input wire dcache_wr_rdy,
	input wire arvalid,
	input wire [3:0] arid,
	input wire [ADDR_W-1:0] araddr,
	input wire [3:0] arlen,
	input wire [2:0] arsize,
	input wire [1:0] arburst,
	input wire arready,
	input wire awvalid,
	input wire [ADDR_W-1:0] awaddr,
	input wire [3:0] awlen,
	input wire [2:0] awsize,
	input wire [1:0] awburst,
	input wire awready,
	input wire wvalid,
	input wire [DATA_W-1:0] wdata,
	input wire [3:0] wstrb,
	input wire wlast,
	input wire wready,
	input wire bvalid
);

	int assert_fails = 0;
	logic [BEAT_CNT_W-1:0] w_cnt;
	logic [3:0] aw_len_q; // length of the burst in flight
	logic wr_open; // write accepted, B not yet seen

	always @(posedge clk)
	begin
		if (!rst)
		begin
			w_cnt <= '0;
			aw_len_q <= '0;
			wr_open <= 1'b0;
		end
		else
		begin
			if (awvalid && awready)
			begin
				aw_len_q <= awlen;
				w_cnt <= '0;
			end
			else if (wvalid && wready)
				w_cnt <= w_cnt + 1'b1;
			if (dcache_wr_req && dcache_wr_rdy)
				wr_open <= 1'b1;
			else if (bvalid)
				wr_open <= 1'b0;
		end
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable({arid, araddr, arlen, arsize, arburst}))
		else begin $error("AR channel changed before arready"); assert_fails++; end

	aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable({awaddr, awlen, awsize, awburst}))
		else begin $error("AW channel changed before awready"); assert_fails++; end

	w_hold: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable({wdata, wstrb, wlast}))
		else begin $error("W channel changed before wready"); assert_fails++; end

	w_last: assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready |-> wlast == (w_cnt == aw_len_q))
		else begin $error("wlast not on the final beat"); assert_fails++; end

	// an accepted icache read goes out next cycle with its own id
	icache_issue: assert property (@(posedge clk) disable iff (!rst)
		icache_rd_req && icache_rd_rdy |=> arvalid && arid == ID_ICACHE)
		else begin $error("accepted icache read not issued with its id"); assert_fails++; end

	no_read_in_write: assert property (@(posedge clk) disable iff (!rst)
		wr_open |-> !$rose(arvalid))
		else begin $error("read issued during a write"); assert_fails++; end

endmodule

`default_nettype wire

//--- dv/axi_cache_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cache_bridge_tb import axi_bridge_pkg::*; ();

	localparam int WAIT_LIMIT = 500;

	logic clk = 1'b0;
	logic rst;
	logic icache_rd_req, dcache_rd_req, dcache_rd_uncached;
	logic [2:0] icache_rd_type, dcache_rd_type, dcache_wr_type;
	logic [ADDR_W-1:0] icache_rd_addr, dcache_rd_addr, dcache_wr_addr;
	logic icache_rd_rdy, icache_ret_valid, icache_ret_last;
	logic dcache_rd_rdy, dcache_ret_valid, dcache_ret_last;
	logic [DATA_W-1:0] icache_ret_data, dcache_ret_data;
	logic dcache_wr_req, dcache_wr_uncached, dcache_wr_rdy;
	logic [3:0] dcache_wr_wstrb;
	logic [LINE_W-1:0] dcache_wr_line;
	logic [DATA_W-1:0] dcache_wr_word;
	logic arvalid, awvalid, wvalid, wlast;
	logic [3:0] arid, arlen, awlen, wstrb;
	logic [ADDR_W-1:0] araddr, awaddr;
	logic [2:0] arsize, awsize;
	logic [1:0] arburst, awburst;
	logic [DATA_W-1:0] wdata;
	// slave side, driven by the memory model
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	logic [3:0] rid = 4'd0;
	logic [DATA_W-1:0] rdata = '0;
	logic rlast = 1'b0;
	logic awready = 1'b0;
	logic wready = 1'b0;
	logic bvalid = 1'b0;

	logic [DATA_W-1:0] mem [1024];
	logic [1:0] ar_wait, r_wait, aw_wait, w_wait, b_wait;
	logic [1:0] rd_phase, wr_phase;
	logic [9:0] r_idx, w_idx;
	logic [3:0] r_beat, r_len, w_beat, w_len;
	logic r_fixed, w_fixed;
	logic [3:0] ar_seen_id, ar_seen_len, aw_seen_len;
	logic [1:0] ar_seen_burst, aw_seen_burst;
	logic [2:0] ar_seen_size, aw_seen_size;
	logic [ADDR_W-1:0] aw_seen_addr;
	logic [DATA_W-1:0] w_log_data [LINE_BEATS];
	logic [3:0] w_log_strb [LINE_BEATS];
	logic w_log_last [LINE_BEATS];
	int w_log_n, b_count;
	logic [DATA_W:0] ic_q[$], dc_q[$]; // {last, data}
	logic [DATA_W-1:0] line_words [LINE_BEATS];
	int errors = 0;
	bit timed_out = 0;

	axi_cache_bridge axi_cache_bridge_inst (.*);

	bind axi_cache_bridge axi_cache_bridge_properties props_inst (.*);

	initial
	begin
		forever #10 clk = ~clk;
	end

	initial
	begin
		for (int i = 0; i < 1024; i++)
			mem[i] = {20'd0, 10'(i), 2'b00} ^ 32'hA5A5_0000;
	end

	always @(posedge clk)
	begin
		if (icache_ret_valid)
			ic_q.push_back({icache_ret_last, icache_ret_data});
		if (dcache_ret_valid)
			dc_q.push_back({dcache_ret_last, dcache_ret_data});
	end

	// read slave, random arready and rvalid gaps
	always @(negedge clk)
	begin
		arready <= 1'b0;
		rvalid <= 1'b0;
		rlast <= 1'b0;
		if (!rst)
		begin
			rd_phase <= 2'd0;
			ar_wait <= 2'd2; // first AR stalls two cycles
		end
		else if (rd_phase == 2'd0 && arvalid)
		begin
			if (ar_wait == 2'd0)
			begin
				arready <= 1'b1;
				r_idx <= araddr[11:2];
				r_len <= arlen;
				r_fixed <= (arburst == BURST_FIXED);
				r_beat <= 4'd0;
				ar_seen_id <= arid;
				ar_seen_len <= arlen;
				ar_seen_burst <= arburst;
				ar_seen_size <= arsize;
				r_wait <= 2'($urandom % 4);
				ar_wait <= 2'($urandom % 4);
				rd_phase <= 2'd1;
			end
			else
				ar_wait <= ar_wait - 1'b1;
		end
		else if (rd_phase == 2'd1)
		begin
			if (r_wait == 2'd0)
			begin
				rvalid <= 1'b1;
				rid <= ar_seen_id;
				rdata <= mem[r_fixed ? r_idx : r_idx + {6'd0, r_beat}];
				rlast <= (r_beat == r_len);
				r_beat <= r_beat + 1'b1;
				r_wait <= 2'($urandom % 4);
				if (r_beat == r_len)
					rd_phase <= 2'd0;
			end
			else
				r_wait <= r_wait - 1'b1;
		end
	end

	// write slave, stores beats into mem and logs them
	always @(negedge clk)
	begin
		awready <= 1'b0;
		wready <= 1'b0;
		bvalid <= 1'b0;
		if (!rst)
		begin
			wr_phase <= 2'd0;
			aw_wait <= 2'd2; // first AW stalls two cycles
			b_count <= 0;
		end
		else if (wr_phase == 2'd0 && awvalid)
		begin
			if (aw_wait == 2'd0)
			begin
				awready <= 1'b1;
				w_idx <= awaddr[11:2];
				w_len <= awlen;
				w_fixed <= (awburst == BURST_FIXED);
				w_beat <= 4'd0;
				w_log_n <= 0;
				aw_seen_len <= awlen;
				aw_seen_burst <= awburst;
				aw_seen_size <= awsize;
				aw_seen_addr <= awaddr;
				w_wait <= 2'($urandom % 4);
				aw_wait <= 2'($urandom % 4);
				wr_phase <= 2'd1;
			end
			else
				aw_wait <= aw_wait - 1'b1;
		end
		else if (wr_phase == 2'd1 && wvalid)
		begin
			if (w_wait == 2'd0)
			begin
				wready <= 1'b1;
				mem[w_fixed ? w_idx : w_idx + {6'd0, w_beat}] <= wdata;
				w_log_data[w_beat] <= wdata;
				w_log_strb[w_beat] <= wstrb;
				w_log_last[w_beat] <= wlast;
				w_log_n <= w_log_n + 1;
				w_beat <= w_beat + 1'b1;
				w_wait <= 2'($urandom % 4);
				b_wait <= 2'($urandom % 4);
				if (w_beat == w_len)
					wr_phase <= 2'd2;
			end
			else
				w_wait <= w_wait - 1'b1;
		end
		else if (wr_phase == 2'd2)
		begin
			if (b_wait == 2'd0)
			begin
				bvalid <= 1'b1;
				b_count <= b_count + 1;
				wr_phase <= 2'd0;
			end
			else
				b_wait <= b_wait - 1'b1;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic request_read(input bit dcache, input logic [ADDR_W-1:0] addr,
		input bit uncached);
		int t;
		t = 0;
		@(negedge clk);
		// request stays up until the bridge can take it
		if (dcache)
		begin
			dcache_rd_req = 1'b1;
			dcache_rd_addr = addr;
			dcache_rd_uncached = uncached;
		end
		else
		begin
			icache_rd_req = 1'b1;
			icache_rd_addr = addr;
		end
		while (!(dcache ? dcache_rd_rdy : icache_rd_rdy) && !timed_out)
		begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT)
			begin
				$display("timeout: read request was never accepted");
				timed_out = 1;
			end
		end
		@(negedge clk);
		icache_rd_req = 1'b0;
		dcache_rd_req = 1'b0;
	endtask

	task automatic wait_beats(input bit dcache, input int n);
		int t;
		t = 0;
		while ((dcache ? dc_q.size() : ic_q.size()) < n && !timed_out)
		begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT)
			begin
				$display("timeout: read data beats did not all arrive");
				timed_out = 1;
			end
		end
	endtask

	// from_line picks the written line instead of the preload pattern
	task automatic check_line(input bit dcache, input logic [ADDR_W-1:0] base,
		input bit from_line);
		logic [DATA_W:0] beat;
		wait_beats(dcache, LINE_BEATS);
		for (int k = 0; k < LINE_BEATS && !timed_out; k++)
		begin
			beat = dcache ? dc_q[k] : ic_q[k];
			check_value("ret_data", beat[DATA_W-1:0],
				from_line ? line_words[k] : (base + 32'(4 * k)) ^ 32'hA5A5_0000);
			check_value("ret_last", 32'(beat[DATA_W]), 32'(k == LINE_BEATS - 1));
		end
	endtask

	task automatic write_and_wait(input logic [ADDR_W-1:0] addr, input bit uncached);
		int t;
		int b_start;
		t = 0;
		b_start = b_count;
		@(negedge clk);
		while (!dcache_wr_rdy && !timed_out)
		begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT)
			begin
				$display("timeout: write request was never accepted");
				timed_out = 1;
			end
		end
		dcache_wr_req = 1'b1;
		dcache_wr_addr = addr;
		dcache_wr_uncached = uncached;
		@(negedge clk);
		dcache_wr_req = 1'b0;
		t = 0;
		while (b_count == b_start && !timed_out)
		begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT)
			begin
				$display("timeout: write response never came");
				timed_out = 1;
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'h0dce0246));
		rst = 1'b0;
		icache_rd_req = 1'b0;
		icache_rd_type = 3'd2;
		icache_rd_addr = '0;
		dcache_rd_req = 1'b0;
		dcache_rd_type = 3'd2;
		dcache_rd_addr = '0;
		dcache_rd_uncached = 1'b0;
		dcache_wr_req = 1'b0;
		dcache_wr_type = 3'd2;
		dcache_wr_addr = '0;
		dcache_wr_wstrb = 4'hF;
		dcache_wr_line = '0;
		dcache_wr_word = '0;
		dcache_wr_uncached = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// icache line read
		request_read(1'b0, 32'h100, 1'b0);
		check_line(1'b0, 32'h100, 1'b0);
		check_value("arid", 32'(ar_seen_id), 32'(ID_ICACHE));
		check_value("arlen", 32'(ar_seen_len), 32'(LEN_LINE));
		check_value("arburst", 32'(ar_seen_burst), 32'(BURST_INCR));
		check_value("arsize", 32'(ar_seen_size), 32'(icache_rd_type));
		check_value("dcache_ret_valid beats", 32'(dc_q.size()), 32'd0);
		ic_q.delete();

		// uncached dcache read
		request_read(1'b1, 32'h204, 1'b1);
		wait_beats(1'b1, 1);
		repeat (6) @(negedge clk);
		check_value("dcache beats", 32'(dc_q.size()), 32'd1);
		check_value("ret_data", dc_q[0][DATA_W-1:0], 32'h204 ^ 32'hA5A5_0000);
		check_value("ret_last", 32'(dc_q[0][DATA_W]), 32'd1);
		check_value("arlen", 32'(ar_seen_len), 32'(LEN_SINGLE));
		check_value("arburst", 32'(ar_seen_burst), 32'(BURST_FIXED));
		check_value("arsize", 32'(ar_seen_size), 32'(dcache_rd_type));
		dc_q.delete();

		// both caches at once, icache wins
		@(negedge clk);
		icache_rd_req = 1'b1;
		icache_rd_addr = 32'h300;
		dcache_rd_req = 1'b1;
		dcache_rd_addr = 32'h340;
		#1;
		check_value("dcache_rd_rdy", 32'(dcache_rd_rdy), 32'd0);
		@(negedge clk);
		icache_rd_req = 1'b0;
		dcache_rd_req = 1'b0;
		check_line(1'b0, 32'h300, 1'b0);
		check_value("arid", 32'(ar_seen_id), 32'(ID_ICACHE));
		ic_q.delete();

		// cached line write, readback requested while it is in flight
		for (int k = 0; k < LINE_BEATS; k++)
		begin
			line_words[k] = $urandom;
			dcache_wr_line[k * DATA_W +: DATA_W] = line_words[k];
		end
		fork
			write_and_wait(32'h400, 1'b0);
			begin
				repeat (2) @(negedge clk);
				request_read(1'b1, 32'h400, 1'b0);
			end
		join
		check_value("awaddr", aw_seen_addr, 32'h400);
		check_value("awlen", 32'(aw_seen_len), 32'(LEN_LINE));
		check_value("awburst", 32'(aw_seen_burst), 32'(BURST_INCR));
		check_value("awsize", 32'(aw_seen_size), 32'(dcache_wr_type));
		check_value("w beats", 32'(w_log_n), 32'(LINE_BEATS));
		for (int k = 0; k < LINE_BEATS; k++)
		begin
			check_value("wdata", w_log_data[k], line_words[k]);
			check_value("wstrb", 32'(w_log_strb[k]), 32'(dcache_wr_wstrb));
			check_value("wlast", 32'(w_log_last[k]), 32'(k == LINE_BEATS - 1));
		end
		check_line(1'b1, 32'h400, 1'b1);
		dc_q.delete();

		// uncached single word write
		dcache_wr_word = $urandom;
		dcache_wr_wstrb = 4'h3;
		write_and_wait(32'h800, 1'b1);
		check_value("awaddr", aw_seen_addr, 32'h800);
		check_value("awlen", 32'(aw_seen_len), 32'(LEN_SINGLE));
		check_value("awburst", 32'(aw_seen_burst), 32'(BURST_FIXED));
		check_value("w beats", 32'(w_log_n), 32'd1);
		check_value("wdata", w_log_data[0], dcache_wr_word);
		check_value("wstrb", 32'(w_log_strb[0]), 32'(dcache_wr_wstrb));
		check_value("wlast", 32'(w_log_last[0]), 32'd1);
		repeat (4) @(negedge clk);

		$display("errors: %0d, assertion failures: %0d, timeouts: %0d", errors,
			axi_cache_bridge_inst.props_inst.assert_fails, timed_out);
		if (errors == 0 && !timed_out && axi_cache_bridge_inst.props_inst.assert_fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/axi_bridge_pkg.sv
rtl/axi_read_port.sv
rtl/axi_write_port.sv
rtl/axi_cache_bridge.sv
dv/axi_cache_bridge_properties.sv
dv/axi_cache_bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= axi_cache_bridge_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
